// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tdc_tb -f list.f
	./obj_dir/Vtdc_tb | awk '{ print } /^TESTS PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: list.f
verilog/tdc_pkg.sv
verilog/wb_pkg.sv
verilog/sample_deser.sv
verilog/tap_encoder.sv
verilog/hit_stamper.sv
verilog/event_fifo_wb.sv
verilog/tdc_top.sv
verification/tdc_tb.sv

// File: verification/tdc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tdc_tb;

	localparam int dlyline_bits = 64;
	localparam int clk_ratio = 4;
	localparam int fifo_depth = 16;
	localparam int n_random = 10;
	localparam int n_miss = 3;
	localparam int n_straddle = 2;
	localparam int n_overflow = fifo_depth + 3;
	// random hits are played twice with short gaps for the fields and long gaps for the coarse count
	localparam int n_events = 2 * n_random + n_miss + n_straddle + n_overflow;
	// each event gets 40 slow periods of 4 ns and the margin covers reset and the final reads
	localparam int watchdog_ns = (n_events * 40 + 200) * 4;

	logic CLK_FAST = 1'b1;
	logic CLK_SLOW = 1'b0;
	logic arst_n;
	logic [dlyline_bits-1:0] sample_in;
	wb_pkg::wb_req_t wb_req;
	wb_pkg::wb_resp_t wb_resp;

	// one delay line snapshot per fast cycle at entry 4*window + slot
	logic [dlyline_bits-1:0] stream [$];
	// expected events in the order they are pushed
	// a slot of -1 is not compared
	tdc_pkg::hit_status_t exp_status [$];
	int exp_slot [$];
	int exp_tap [$];
	int exp_win [$];

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_start = 0;

	tdc_top #(
		.dlyline_bits      (dlyline_bits),
		.clk_ratio         (clk_ratio),
		.internally_rising (1'b1),
		.fifo_depth        (fifo_depth)
	) dut_i (
		.CLK_FAST  (CLK_FAST),
		.CLK_SLOW  (CLK_SLOW),
		.arst_n    (arst_n),
		.sample_in (sample_in),
		.wb_req    (wb_req),
		.wb_resp   (wb_resp)
	);

	// fast clock starts high so that its rising edges line up with the slow ones
	always #0.5 CLK_FAST = ~CLK_FAST;
	always #2 CLK_SLOW = ~CLK_SLOW;

	initial begin
		#(watchdog_ns);
		$display("ERROR: the run did not finish within %0d ns", watchdog_ns);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic check_eq(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("MISMATCH at %0.1f ns: %s is %0d, expected %0d", $realtime, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			$display("ERROR at %0.1f ns: %s", $realtime, what);
			errors++;
		end
	endtask

	// thermometer word with the first n taps passed
	function automatic logic [dlyline_bits-1:0] therm(input int n);
		logic [dlyline_bits-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i] = 1'b1;
		end
		return v;
	endfunction

	task automatic place(input int idx, input logic [dlyline_bits-1:0] value);
		while (stream.size() <= idx) begin
			stream.push_back('0);
		end
		stream[idx] = value;
	endtask

	task automatic expect_event(input tdc_pkg::hit_status_t st, input int slot, input int tap,
			input int win);
		exp_status.push_back(st);
		exp_slot.push_back(slot);
		exp_tap.push_back(tap);
		exp_win.push_back(win);
	endtask

	// the edge has passed n taps in slot s and the line then stays full for two fast cycles
	task automatic add_hit(input int w, input int s, input int n);
		place(clk_ratio * w + s, therm(n));
		place(clk_ratio * w + s + 1, '1);
		place(clk_ratio * w + s + 2, '1);
		expect_event(tdc_pkg::HIT, s, n, w);
	endtask

	// the line jumps from empty to full at slot s
	// for slot 0 the empty snapshot is the last one of the previous window
	task automatic add_miss(input int w, input int s);
		place(clk_ratio * w + s, '1);
		place(clk_ratio * w + s + 1, '1);
		expect_event(tdc_pkg::MISSED, -1, 0, w);
	endtask

	// the edge is seen in the last slot of window w and again in the first slot of w+1
	task automatic add_straddle(input int w, input int n1, input int n2);
		place(clk_ratio * w + clk_ratio - 1, therm(n1));
		place(clk_ratio * (w + 1), therm(n2));
		place(clk_ratio * (w + 1) + 1, '1);
		expect_event(tdc_pkg::HIT, clk_ratio - 1, n1, w);
	endtask

	task automatic play_stream();
		// an idle tail longer than the pipeline lets the FIFO fill completely before it is read
		for (int i = 0; i < 8 * clk_ratio; i++) begin
			stream.push_back('0);
		end
		@(posedge CLK_SLOW);
		#0.1;
		// a snapshot driven after the third fast edge is captured on the next slow edge
		// and becomes slot 0 of the window transferred one slow cycle later
		repeat (3) @(posedge CLK_FAST);
		foreach (stream[i]) begin
			#0.1;
			sample_in = stream[i];
			@(posedge CLK_FAST);
		end
	endtask

	// one Wishbone classic cycle that expects a single ack lasting one cycle
	task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int waited;
		bit acked;
		waited = 0;
		acked = 1'b0;
		rdata = '0;
		@(posedge CLK_SLOW);
		#0.1;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
		while (!acked && waited < 8) begin
			@(posedge CLK_SLOW);
			#0.1;
			waited++;
			if (wb_resp.ack) begin
				acked = 1'b1;
				rdata = wb_resp.dat_r;
			end
		end
		wb_req = '0;
		check_true(acked, "a bus cycle got no acknowledge");
		@(posedge CLK_SLOW);
		#0.1;
		check_true(!wb_resp.ack, "the acknowledge stayed high for more than one cycle");
	endtask

	task automatic read_status(output int count, output bit ovf);
		logic [31:0] word;
		wb_cycle(1'b0, wb_pkg::ADR_STATUS, 32'd0, word);
		count = int'(word[7:0]);
		ovf = word[wb_pkg::STATUS_OVF_BIT];
	endtask

	task automatic wait_count(input int expected);
		int count;
		bit ovf;
		int polls;
		polls = 0;
		read_status(count, ovf);
		while (count != expected && polls < 40) begin
			read_status(count, ovf);
			polls++;
		end
		check_true(count == expected, "the FIFO count never reached the expected number of events");
	endtask

	// pops n events and compares them with the model in push order
	task automatic read_events(input int n, input bit fields, input bit coarse);
		logic [31:0] word;
		tdc_pkg::event_word_t ev;
		int prev_coarse;
		prev_coarse = 0;
		for (int i = 0; i < n; i++) begin
			wb_cycle(1'b0, wb_pkg::ADR_EVENT, 32'd0, word);
			ev.raw = word;
			if (fields) begin
				check_eq($sformatf("event %0d status", i), int'(ev.fields.status), int'(exp_status[i]));
				if (exp_slot[i] >= 0) begin
					check_eq($sformatf("event %0d slot", i), int'(ev.fields.slot), exp_slot[i]);
				end
				check_eq($sformatf("event %0d tap", i), int'(ev.fields.tap), exp_tap[i]);
			end
			// the coarse count steps once per slow window and is compared modulo 2**20
			if (coarse && i > 0) begin
				check_eq($sformatf("event %0d coarse step", i),
					(int'(ev.fields.coarse) - prev_coarse) & 32'hfffff,
					(exp_win[i] - exp_win[i-1]) & 32'hfffff);
			end
			prev_coarse = int'(ev.fields.coarse);
		end
	endtask

	task automatic start_test();
		test_err_start = errors;
		stream.delete();
		exp_status.delete();
		exp_slot.delete();
		exp_tap.delete();
		exp_win.delete();
	endtask

	task automatic end_test(input string name);
		int count;
		bit ovf;
		read_status(count, ovf);
		check_eq({name, ": count after the test"}, count, 0);
		tests_run++;
		if (errors == test_err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - test_err_start);
		end
	endtask

	initial begin
		int w;
		int n1;
		int count;
		bit ovf;
		logic [31:0] word;
		void'($urandom(52));
		arst_n = 1'b0;
		sample_in = '0;
		wb_req = '0;
		repeat (8) @(posedge CLK_SLOW);
		#0.1;
		arst_n = 1'b1;

		start_test();
		w = 1;
		for (int i = 0; i < n_random; i++) begin
			add_hit(w, $urandom_range(clk_ratio - 1, 0), $urandom_range(dlyline_bits - 2, 2));
			w += 3 + $urandom_range(2, 0);
		end
		play_stream();
		wait_count(n_random);
		read_events(n_random, 1'b1, 1'b0);
		end_test("random single hits");

		// long and uneven gaps so that the coarse steps vary
		start_test();
		w = 1;
		for (int i = 0; i < n_random; i++) begin
			add_hit(w, $urandom_range(clk_ratio - 1, 0), $urandom_range(dlyline_bits - 2, 2));
			w += 3 + $urandom_range(17, 0);
		end
		play_stream();
		wait_count(n_random);
		read_events(n_random, 1'b0, 1'b1);
		end_test("coarse stamping");

		start_test();
		w = 1;
		for (int i = 0; i < n_miss; i++) begin
			add_miss(w, $urandom_range(clk_ratio - 1, 0));
			w += 4;
		end
		play_stream();
		wait_count(n_miss);
		read_events(n_miss, 1'b1, 1'b1);
		end_test("miss detection");

		start_test();
		w = 1;
		for (int i = 0; i < n_straddle; i++) begin
			n1 = $urandom_range(dlyline_bits / 2, 2);
			add_straddle(w, n1, $urandom_range(dlyline_bits - 2, n1 + 1));
			w += 4;
		end
		play_stream();
		wait_count(n_straddle);
		read_events(n_straddle, 1'b1, 1'b1);
		end_test("straddle suppression");

		// the last three events find the FIFO full and are lost
		start_test();
		w = 1;
		for (int i = 0; i < n_overflow; i++) begin
			add_hit(w, $urandom_range(clk_ratio - 1, 0), $urandom_range(dlyline_bits - 2, 2));
			w += 3;
		end
		play_stream();
		wait_count(fifo_depth);
		read_status(count, ovf);
		check_eq("count when full", count, fifo_depth);
		check_eq("overflow flag when full", int'(ovf), 1);
		read_events(fifo_depth, 1'b1, 1'b1);
		wb_cycle(1'b1, wb_pkg::ADR_STATUS, 32'h1 << wb_pkg::STATUS_OVF_BIT, word);
		read_status(count, ovf);
		check_eq("overflow flag after clear", int'(ovf), 0);
		end_test("overflow");

		start_test();
		wb_cycle(1'b0, wb_pkg::ADR_EVENT, 32'd0, word);
		check_eq("pop from an empty FIFO", int'(word), 0);
		end_test("empty read");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/event_fifo_wb.sv
`timescale 1ns/10ps
`default_nettype none

module event_fifo_wb #(
	parameter int fifo_depth = 16
) (
	input  wire                      CLK_SLOW,
	input  wire                      arst_n,
	input  wire                      push,
	input  wire tdc_pkg::event_word_t event_word,
	input  wire wb_pkg::wb_req_t     wb_req,
	output wb_pkg::wb_resp_t         wb_resp
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	// circular buffer of raw event words
	logic [31:0] mem [fifo_depth-1:0];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic ovf;

	logic full;
	logic empty;
	logic access;
	logic do_push;
	logic do_pop;
	logic ovf_clr;
	logic ack_q;
	logic [31:0] dat_r_q;
	logic [31:0] status_word;

	// pointer step with an explicit wrap, the depth need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(fifo_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full  = (count == cnt_w'(fifo_depth));
	assign empty = (count == '0);

	// the ack cycle itself is not taken as a new request
	assign access  = wb_req.cyc && wb_req.stb && !ack_q;
	assign do_pop  = access && !wb_req.we && (wb_req.adr == wb_pkg::ADR_EVENT) && !empty;
	// a full FIFO still takes a push when a pop frees a slot in the same cycle
	assign do_push = push && (!full || do_pop);
	assign ovf_clr = access && wb_req.we && (wb_req.adr == wb_pkg::ADR_STATUS) &&
		wb_req.dat_w[wb_pkg::STATUS_OVF_BIT];

	always_comb begin
		status_word = '0;
		status_word[7:0] = 8'(count);
		status_word[wb_pkg::STATUS_OVF_BIT] = ovf;
	end

	always_ff @(posedge CLK_SLOW or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovf    <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			// one ack per accepted cycle, on the next edge
			ack_q <= access;
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
			// a lost event in the same cycle as a clear keeps the flag set
			if (push && !do_push) begin
				ovf <= 1'b1;
			end else if (ovf_clr) begin
				ovf <= 1'b0;
			end
		end
	end

	// on a full FIFO the write and the read hit the same entry, the read sees the old word
	always_ff @(posedge CLK_SLOW) begin
		if (do_push) begin
			mem[wr_ptr] <= event_word.raw;
		end
		if (access) begin
			if (!wb_req.we && (wb_req.adr == wb_pkg::ADR_STATUS)) begin
				dat_r_q <= status_word;
			end else if (do_pop) begin
				dat_r_q <= mem[rd_ptr];
			end else begin
				dat_r_q <= '0;
			end
		end
	end

	assign wb_resp = '{ack: ack_q, dat_r: dat_r_q};

endmodule

`default_nettype wire

// File: verilog/hit_stamper.sv
`timescale 1ns/10ps
`default_nettype none

module hit_stamper #(
	parameter int clk_ratio = 4
) (
	input  wire                   CLK_SLOW,
	input  wire                   arst_n,
	input  wire tdc_pkg::enc_out_t in,
	output logic                  push,
	output tdc_pkg::event_word_t  event_word
);

	// latest fast cycle of a slow window
	localparam tdc_pkg::slot_t last_slot = tdc_pkg::slot_t'(clk_ratio - 1);

	tdc_pkg::coarse_t coarse_q;
	// previous cycle carried a hit, and in which slot
	logic prev_hit;
	tdc_pkg::slot_t prev_slot;
	logic straddle;

	// an edge sampled at the end of one window is still visible at the start of
	// the next one, the second report of it is a duplicate
	assign straddle = in.valid && (in.status == tdc_pkg::HIT) && (in.slot == '0) &&
		prev_hit && (prev_slot == last_slot);

	always_ff @(posedge CLK_SLOW or negedge arst_n) begin
		if (!arst_n) begin
			coarse_q  <= '0;
			prev_hit  <= 1'b0;
			prev_slot <= '0;
			push      <= 1'b0;
		end else begin
			// counts every slow edge and wraps at the top
			coarse_q  <= coarse_q + 1'b1;
			prev_hit  <= in.valid && (in.status == tdc_pkg::HIT);
			prev_slot <= in.valid ? in.slot : '0;
			push      <= in.valid && !straddle;
		end
	end

	// event fields are captured with the counter value seen at this edge
	always_ff @(posedge CLK_SLOW) begin
		if (in.valid) begin
			event_word.fields.status <= in.status;
			event_word.fields.coarse <= coarse_q;
			event_word.fields.slot   <= in.slot;
			event_word.fields.tap    <= in.tap;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sample_deser.sv
`timescale 1ns/10ps
`default_nettype none

module sample_deser #(
	parameter int dlyline_bits = 64,
	parameter int clk_ratio = 4,
	parameter bit internally_rising = 1'b1
) (
	input  wire                      CLK_FAST,
	input  wire                      CLK_SLOW,
	input  wire                      arst_n,
	input  wire [dlyline_bits-1:0]   sample_in,
	output tdc_pkg::deser_out_t      out
);

	// level the first taps take once the edge entered the line
	localparam logic lead = internally_rising;
	// level the last taps still hold while the edge is inside the line
	localparam logic trail = !internally_rising;

	// fast shift register with the newest snapshot at index 0
	// the extra entry at index clk_ratio is the last snapshot of the previous window
	logic [dlyline_bits-1:0] fast_sr [clk_ratio:0];
	// copy of the whole shift register taken on the slow edge
	logic [dlyline_bits-1:0] slow_sr [clk_ratio:0];

	logic [clk_ratio-1:0] hit_flags;
	logic [clk_ratio-1:0] miss_flags;
	logic [1:0] sel_idx;
	tdc_pkg::hit_status_t status_d;

	logic out_valid;
	tdc_pkg::hit_status_t out_status;
	tdc_pkg::slot_t out_slot;
	logic [dlyline_bits-1:0] out_sample;

	// every fast edge pushes a new snapshot in and ages the older ones
	always_ff @(posedge CLK_FAST) begin
		fast_sr[0] <= sample_in;
		for (int i = 1; i <= clk_ratio; i++) begin
			fast_sr[i] <= fast_sr[i-1];
		end
	end

	// both clocks rise together, so this picks up the snapshots of the fast
	// cycles before the current slow edge and the one just before them
	always_ff @(posedge CLK_SLOW) begin
		for (int i = 0; i <= clk_ratio; i++) begin
			slow_sr[i] <= fast_sr[i];
		end
	end

	// an edge is inside a snapshot when it reached the first taps but not the last
	// two taps at each end are checked so that a single bubble does not hide it
	always_comb begin
		for (int k = 0; k < clk_ratio; k++) begin
			hit_flags[k] = (slow_sr[k][0] == lead || slow_sr[k][1] == lead) &&
				(slow_sr[k][dlyline_bits-2] == trail || slow_sr[k][dlyline_bits-1] == trail);
		end
	end

	// the line went from fully idle to fully passed within one fast cycle,
	// so the edge outran the delay line and its fine time is lost
	// the oldest snapshot of the window is compared with the one before the window
	always_comb begin
		for (int k = 0; k < clk_ratio; k++) begin
			if (internally_rising) begin
				miss_flags[k] = (&slow_sr[k]) && !(|slow_sr[k+1]);
			end else begin
				miss_flags[k] = !(|slow_sr[k]) && (&slow_sr[k+1]);
			end
		end
	end

	// priority search for the oldest hit where a higher index means an older snapshot
	// the ascending loop lets the last match win
	always_comb begin
		sel_idx = '0;
		for (int k = 0; k < clk_ratio; k++) begin
			if (hit_flags[k]) begin
				sel_idx = 2'(k);
			end
		end
	end

	// a miss outranks any hit found in the same slow cycle
	always_comb begin
		if (|miss_flags) begin
			status_d = tdc_pkg::MISSED;
		end else if (|hit_flags) begin
			status_d = tdc_pkg::HIT;
		end else begin
			status_d = tdc_pkg::IDLE;
		end
	end

	always_ff @(posedge CLK_SLOW or negedge arst_n) begin
		if (!arst_n) begin
			out_valid  <= 1'b0;
			out_status <= tdc_pkg::IDLE;
			out_slot   <= '0;
		end else begin
			out_valid  <= (status_d != tdc_pkg::IDLE);
			out_status <= status_d;
			// turn the shift register index into a slot counted from the earliest cycle
			out_slot   <= tdc_pkg::slot_t'(clk_ratio - 1) - sel_idx;
		end
	end

	always_ff @(posedge CLK_SLOW) begin
		out_sample <= slow_sr[sel_idx];
	end

	assign out = '{valid: out_valid, status: out_status, slot: out_slot,
		sample: 64'(out_sample)};

endmodule

`default_nettype wire

// File: verilog/tap_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module tap_encoder #(
	parameter int dlyline_bits = 64
) (
	input  wire                   CLK_SLOW,
	input  wire                   arst_n,
	input  wire tdc_pkg::deser_out_t in,
	output tdc_pkg::enc_out_t     out
);

	// number of ones seen in the selected thermometer
	tdc_pkg::tap_t ones_cnt;
	// tap index as it is registered
	tdc_pkg::tap_t tap_d;

	logic out_valid;
	tdc_pkg::hit_status_t out_status;
	tdc_pkg::slot_t out_slot;
	tdc_pkg::tap_t out_tap;

	// a plain population count over the delay line taps
	// a bubble moves a one to another position but keeps the total, so the
	// count still gives the edge position where a first-zero search would not
	always_comb begin
		ones_cnt = '0;
		for (int i = 0; i < dlyline_bits; i++) begin
			ones_cnt = ones_cnt + tdc_pkg::tap_t'(in.sample[i]);
		end
	end

	// a missed edge has no usable fine position, it is reported with tap 0
	always_comb begin
		if (in.status == tdc_pkg::MISSED) begin
			tap_d = '0;
		end else begin
			tap_d = ones_cnt;
		end
	end

	// handshake fields follow the sample one register later
	always_ff @(posedge CLK_SLOW or negedge arst_n) begin
		if (!arst_n) begin
			out_valid  <= 1'b0;
			out_status <= tdc_pkg::IDLE;
			out_slot   <= '0;
		end else begin
			out_valid  <= in.valid;
			out_status <= in.status;
			out_slot   <= in.slot;
		end
	end

	// the count is only looked at while valid is high
	always_ff @(posedge CLK_SLOW) begin
		out_tap <= tap_d;
	end

	assign out = '{valid: out_valid, status: out_status, slot: out_slot, tap: out_tap};

endmodule

`default_nettype wire

// File: verilog/tdc_pkg.sv
`default_nettype none

package tdc_pkg;

	// classification of one slow cycle, the same code travels through every stage
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		HIT    = 2'd1,
		MISSED = 2'd2
	} hit_status_t;

	// fast cycle inside the slow cycle that saw the edge, 0 is the earliest one
	typedef logic [1:0] slot_t;

	// number of delay line taps the edge had passed when it was sampled
	typedef logic [7:0] tap_t;

	// free running slow cycle count, wraps silently
	typedef logic [19:0] coarse_t;

	// selected snapshot leaving the input stage
	// bits above the delay line length are zero
	typedef struct packed {
		logic        valid;
		hit_status_t status;
		slot_t       slot;
		logic [63:0] sample;
	} deser_out_t;

	// encoded hit leaving the tap encoder
	typedef struct packed {
		logic        valid;
		hit_status_t status;
		slot_t       slot;
		tap_t        tap;
	} enc_out_t;

	// layout of one stored event, status in the two top bits and tap at the bottom
	typedef struct packed {
		hit_status_t status;
		coarse_t     coarse;
		slot_t       slot;
		tap_t        tap;
	} event_fields_t;

	// the FIFO and the bus only see the raw word, the stamper fills in the fields
	typedef union packed {
		logic [31:0]   raw;
		event_fields_t fields;
	} event_word_t;

endpackage

`default_nettype wire

// File: verilog/tdc_top.sv
`timescale 1ns/10ps
`default_nettype none

module tdc_top #(
	parameter int dlyline_bits = 64,
	parameter int clk_ratio = 4,
	parameter bit internally_rising = 1'b1,
	parameter int fifo_depth = 16
) (
	input  wire                    CLK_FAST,
	input  wire                    CLK_SLOW,
	input  wire                    arst_n,
	input  wire [dlyline_bits-1:0] sample_in,
	input  wire wb_pkg::wb_req_t   wb_req,
	output wb_pkg::wb_resp_t       wb_resp
);

	// selected snapshot, one per slow cycle
	tdc_pkg::deser_out_t deser_out;
	// tap index of that snapshot
	tdc_pkg::enc_out_t enc_out;
	// time stamped event and its write strobe
	logic ev_push;
	tdc_pkg::event_word_t ev_word;

	sample_deser #(
		.dlyline_bits      (dlyline_bits),
		.clk_ratio         (clk_ratio),
		.internally_rising (internally_rising)
	) deser_i (
		.CLK_FAST  (CLK_FAST),
		.CLK_SLOW  (CLK_SLOW),
		.arst_n    (arst_n),
		.sample_in (sample_in),
		.out       (deser_out)
	);

	tap_encoder #(
		.dlyline_bits (dlyline_bits)
	) enc_i (
		.CLK_SLOW (CLK_SLOW),
		.arst_n   (arst_n),
		.in       (deser_out),
		.out      (enc_out)
	);

	hit_stamper #(
		.clk_ratio (clk_ratio)
	) stamp_i (
		.CLK_SLOW   (CLK_SLOW),
		.arst_n     (arst_n),
		.in         (enc_out),
		.push       (ev_push),
		.event_word (ev_word)
	);

	event_fifo_wb #(
		.fifo_depth (fifo_depth)
	) fifo_i (
		.CLK_SLOW   (CLK_SLOW),
		.arst_n     (arst_n),
		.push       (ev_push),
		.event_word (ev_word),
		.wb_req     (wb_req),
		.wb_resp    (wb_resp)
	);

endmodule

`default_nettype wire

// File: verilog/wb_pkg.sv
`default_nettype none

package wb_pkg;

	// master side of a Wishbone classic cycle
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr;
		logic [31:0] dat_w;
	} wb_req_t;

	// slave side, dat_r only means something while ack is high
	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_resp_t;

	// status word: FIFO count in the low byte and the sticky overflow flag above it
	localparam logic [1:0] ADR_STATUS = 2'd0;

	// every read here pops one event, an empty FIFO reads as zero
	localparam logic [1:0] ADR_EVENT = 2'd1;

	// position of the overflow flag in the status word
	// writing a one to it clears the flag
	localparam int STATUS_OVF_BIT = 8;

endpackage

`default_nettype wire
